// File: verilog/tile_pkg.sv
// Shared widths, flit format, slave map and boot ROM contents for the compute tile
// Only classic single Wishbone cycles are modelled; no cti/bte/rty
`default_nettype none

package tile_pkg;

   localparam int DW = 32;                   // Data and address width
   localparam int SW = DW / 8;               // Byte selects per word

   typedef logic [DW-1:0] word_t;
   typedef logic [SW-1:0] sel_t;

   localparam int FLIT_TYPE_W = 2;

   typedef enum logic [FLIT_TYPE_W-1:0] {
      FLIT_PAYLOAD = 2'd0,
      FLIT_HEAD    = 2'd1,
      FLIT_TAIL    = 2'd2,
      FLIT_SINGLE  = 2'd3
   } flit_type_e;

   typedef struct packed {
      flit_type_e ftype;                     // Upper two bits of the link
      word_t      data;
   } flit_t;

   localparam int NR_MASTERS = 2;            // Instruction and data port
   localparam int NR_SLAVES  = 3;

   localparam int SLV_RAM = 0;
   localparam int SLV_NA  = 1;
   localparam int SLV_ROM = 2;

   localparam int ROM_WORDS = 32;

   // Boot image is a simple counting pattern
   function automatic word_t rom_word(input int unsigned idx);
      return 32'hB007_0000 + idx * 32'h0000_0101;
   endfunction

endpackage

`default_nettype wire

// File: verilog/wb_bus.sv
// Shared Wishbone classic bus, round-robin grant held for a whole cyc
// Unmapped addresses (top nibble 8..D) end with a one-cycle err
`timescale 1ns/1ps
`default_nettype none

module wb_bus import tile_pkg::*; (
   input  wire                          clk_i,
   input  wire                          arst_n_i,

   input  wire   [NR_MASTERS-1:0]       m_cyc_i,
   input  wire   [NR_MASTERS-1:0]       m_stb_i,
   input  wire   [NR_MASTERS-1:0]       m_we_i,
   input  wire word_t [NR_MASTERS-1:0]  m_adr_i,
   input  wire sel_t  [NR_MASTERS-1:0]  m_sel_i,
   input  wire word_t [NR_MASTERS-1:0]  m_dat_i,
   output word_t [NR_MASTERS-1:0]       m_dat_o,
   output logic  [NR_MASTERS-1:0]       m_ack_o,
   output logic  [NR_MASTERS-1:0]       m_err_o,

   output logic  [NR_SLAVES-1:0]        s_cyc_o,
   output logic  [NR_SLAVES-1:0]        s_stb_o,
   output logic  [NR_SLAVES-1:0]        s_we_o,
   output word_t [NR_SLAVES-1:0]        s_adr_o,
   output sel_t  [NR_SLAVES-1:0]        s_sel_o,
   output word_t [NR_SLAVES-1:0]        s_dat_o,
   input  wire word_t [NR_SLAVES-1:0]   s_dat_i,
   input  wire   [NR_SLAVES-1:0]        s_ack_i
);

   localparam int GW = (NR_MASTERS > 1) ? $clog2(NR_MASTERS) : 1;

   logic                 busy_q;
   logic [GW-1:0]        gnt_q;                // Also the last granted master
   logic [GW-1:0]        nxt_gnt;
   logic                 err_q;

   logic                 g_cyc, g_stb;
   word_t                g_adr;
   logic [NR_SLAVES-1:0] slv_sel;
   logic                 unmapped;
   word_t                r_dat;
   logic                 r_ack;

   // Round robin, first requester after the last grant wins
   always_comb begin
      int cand;
      nxt_gnt = gnt_q;
      for (int k = NR_MASTERS; k >= 1; k--) begin
         cand = (int'(gnt_q) + k) % NR_MASTERS;
         if (m_cyc_i[cand])
            nxt_gnt = GW'(cand);
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         busy_q <= 1'b0;
         gnt_q  <= '0;
         err_q  <= 1'b0;
      end else begin
         if (!busy_q) begin
            if (|m_cyc_i) begin
               busy_q <= 1'b1;
               gnt_q  <= nxt_gnt;
            end
         end else if (!m_cyc_i[gnt_q]) begin
            busy_q <= 1'b0;                     // Released, rearbitrate next cycle
         end
         err_q <= g_stb & unmapped & ~err_q;    // Single cycle pulse
      end
   end

   assign g_cyc = busy_q & m_cyc_i[gnt_q];
   assign g_stb = g_cyc & m_stb_i[gnt_q];
   assign g_adr = m_adr_i[gnt_q];

   // Address decode on the high bits
   always_comb begin
      slv_sel          = '0;
      slv_sel[SLV_RAM] = ~g_adr[31];
      slv_sel[SLV_NA]  = (g_adr[31:28] == 4'hE);
      slv_sel[SLV_ROM] = (g_adr[31:28] == 4'hF);
   end

   assign unmapped = ~|slv_sel;

   always_comb begin
      for (int s = 0; s < NR_SLAVES; s++) begin
         s_cyc_o[s] = g_cyc & slv_sel[s];
         s_stb_o[s] = g_stb & slv_sel[s];
         s_we_o[s]  = m_we_i[gnt_q];
         s_adr_o[s] = g_adr;
         s_sel_o[s] = m_sel_i[gnt_q];
         s_dat_o[s] = m_dat_i[gnt_q];
      end
   end

   always_comb begin
      r_dat = '0;
      r_ack = 1'b0;
      for (int s = 0; s < NR_SLAVES; s++) begin
         if (slv_sel[s]) begin
            r_dat = s_dat_i[s];
            r_ack = s_ack_i[s];
         end
      end
   end

   always_comb begin
      for (int m = 0; m < NR_MASTERS; m++) begin
         m_dat_o[m] = (busy_q && gnt_q == GW'(m)) ? r_dat : '0;
         m_ack_o[m] = g_cyc & r_ack & (gnt_q == GW'(m));
         m_err_o[m] = busy_q & err_q & (gnt_q == GW'(m));
      end
   end

endmodule

`default_nettype wire

// File: verilog/wb_sram.sv
// Single-port RAM slave, one-cycle registered ack and read data
// MEM_WORDS must be a power of two; upper address bits alias
`timescale 1ns/1ps
`default_nettype none

module wb_sram import tile_pkg::*; #(
   parameter int MEM_WORDS = 1024
) (
   input  wire         clk_i,
   input  wire         arst_n_i,
   input  wire         cyc_i,
   input  wire         stb_i,
   input  wire         we_i,
   input  wire word_t  adr_i,
   input  wire sel_t   sel_i,
   input  wire word_t  dat_i,
   output word_t       dat_o,
   output logic        ack_o
);

   localparam int IW = $clog2(MEM_WORDS);

   word_t          mem [MEM_WORDS];
   logic [IW-1:0]  idx;
   logic           req;

   assign idx = adr_i[IW+1:2];                 // Word index
   assign req = cyc_i & stb_i & ~ack_o;        // No second ack on a held stb

   always_ff @(posedge clk_i) begin
      if (req) begin
         if (we_i) begin
            for (int b = 0; b < SW; b++)
               if (sel_i[b])
                  mem[idx][8*b +: 8] <= dat_i[8*b +: 8];
         end else begin
            dat_o <= mem[idx];
         end
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) ack_o <= 1'b0;
      else           ack_o <= req;
   end

endmodule

`default_nettype wire

// File: verilog/bootrom.sv
// Boot ROM slave, contents from tile_pkg::rom_word, aliased every ROM_WORDS
// Writes are acknowledged and dropped
`timescale 1ns/1ps
`default_nettype none

module bootrom import tile_pkg::*; (
   input  wire         clk_i,
   input  wire         arst_n_i,
   input  wire         cyc_i,
   input  wire         stb_i,
   input  wire word_t  adr_i,
   output word_t       dat_o,
   output logic        ack_o
);

   localparam int RW = $clog2(ROM_WORDS);

   logic req;

   assign req = cyc_i & stb_i & ~ack_o;

   always_ff @(posedge clk_i) begin
      if (req)
         dat_o <= rom_word(int'(adr_i[RW+1:2]));
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) ack_o <= 1'b0;
      else           ack_o <= req;       // One cycle after stb
   end

endmodule

`default_nettype wire

// File: verilog/na_mp_simple.sv
// Message-passing NA: TX window 0x00-0x0C, RX_DATA 0x10, STATUS 0x14
// FIFO_DEPTH must be a power of two and at least 2; single virtual channel
`timescale 1ns/1ps
`default_nettype none

module na_mp_simple import tile_pkg::*; #(
   parameter int FIFO_DEPTH = 4
) (
   input  wire         clk_i,
   input  wire         arst_n_i,
   input  wire         cyc_i,
   input  wire         stb_i,
   input  wire         we_i,
   input  wire word_t  adr_i,
   input  wire word_t  dat_i,
   output word_t       dat_o,
   output logic        ack_o,

   input  wire flit_t  noc_in_flit_i,
   input  wire         noc_in_valid_i,
   output logic        noc_in_ready_o,
   output flit_t       noc_out_flit_o,
   output logic        noc_out_valid_o,
   input  wire         noc_out_ready_i,

   output logic        irq_o
);

   localparam int PW = $clog2(FIFO_DEPTH);
   localparam int TX = 0;
   localparam int RX = 1;
   localparam logic [4:0] OFS_RX_DATA = 5'h10;
   localparam logic [4:0] OFS_STATUS  = 5'h14;

   flit_t [1:0]  fifo_din, fifo_dout;
   logic  [1:0]  fifo_push, fifo_pop, fifo_full, fifo_empty;

   logic         req, tx_wr, rx_rd, st_rd;
   logic [1:0]   rx_head_type;
   word_t        rd_dat;

   for (genvar f = 0; f < 2; f++) begin : g_fifo
      flit_t          mem [FIFO_DEPTH];
      logic [PW-1:0]  wr_ptr, rd_ptr;
      logic [PW:0]    count;

      always_ff @(posedge clk_i) begin
         if (fifo_push[f]) mem[wr_ptr] <= fifo_din[f];
      end

      always_ff @(posedge clk_i or negedge arst_n_i) begin
         if (!arst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
         end else begin
            if (fifo_push[f]) wr_ptr <= wr_ptr + 1'b1;   // Wraps at depth
            if (fifo_pop[f])  rd_ptr <= rd_ptr + 1'b1;
            case ({fifo_push[f], fifo_pop[f]})
               2'b10:   count <= count + 1'b1;
               2'b01:   count <= count - 1'b1;
               default: count <= count;
            endcase
         end
      end

      assign fifo_dout[f]  = mem[rd_ptr];
      assign fifo_full[f]  = (count == (PW+1)'(FIFO_DEPTH));
      assign fifo_empty[f] = (count == '0);
   end

   // Bus side decode
   assign req   = cyc_i & stb_i & ~ack_o;
   assign tx_wr = we_i & ~adr_i[4];
   assign rx_rd = ~we_i & (adr_i[4:0] == OFS_RX_DATA);
   assign st_rd = ~we_i & (adr_i[4:0] == OFS_STATUS);

   // TX write into a full FIFO holds off the ack
   assign fifo_push[TX] = req & tx_wr & ~fifo_full[TX];
   assign fifo_din[TX]  = '{ftype: flit_type_e'(adr_i[3:2]), data: dat_i};
   assign fifo_pop[RX]  = req & rx_rd & ~fifo_empty[RX];

   // Network side
   assign fifo_push[RX]   = noc_in_valid_i & ~fifo_full[RX];
   assign fifo_din[RX]    = noc_in_flit_i;
   assign noc_in_ready_o  = ~fifo_full[RX];
   assign fifo_pop[TX]    = noc_out_ready_i & ~fifo_empty[TX];
   assign noc_out_flit_o  = fifo_dout[TX];
   assign noc_out_valid_o = ~fifo_empty[TX];
   assign irq_o           = ~fifo_empty[RX];   // Level while flits wait

   assign rx_head_type = fifo_empty[RX] ? 2'b00 : fifo_dout[RX].ftype;

   always_comb begin
      rd_dat = '0;
      if (rx_rd && !fifo_empty[RX])
         rd_dat = fifo_dout[RX].data;
      else if (st_rd)
         rd_dat = {28'h0, fifo_full[TX], rx_head_type, ~fifo_empty[RX]};
   end

   always_ff @(posedge clk_i) begin
      if (req) dat_o <= rd_dat;
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) ack_o <= 1'b0;
      else           ack_o <= req & ~(tx_wr & fifo_full[TX]);
   end

endmodule

`default_nettype wire

// File: verilog/compute_tile.sv
// Tile top with two external master ports, local RAM, boot ROM and message NA
// MEM_WORDS and FIFO_DEPTH must be powers of two
`timescale 1ns/1ps
`default_nettype none

module compute_tile import tile_pkg::*; #(
   parameter int MEM_WORDS  = 1024,
   parameter int FIFO_DEPTH = 4
) (
   input  wire         clk_i,
   input  wire         arst_n_i,

   input  wire         m0_cyc_i,           // Instruction port
   input  wire         m0_stb_i,
   input  wire         m0_we_i,
   input  wire word_t  m0_adr_i,
   input  wire sel_t   m0_sel_i,
   input  wire word_t  m0_dat_i,
   output word_t       m0_dat_o,
   output logic        m0_ack_o,
   output logic        m0_err_o,

   input  wire         m1_cyc_i,           // Data port
   input  wire         m1_stb_i,
   input  wire         m1_we_i,
   input  wire word_t  m1_adr_i,
   input  wire sel_t   m1_sel_i,
   input  wire word_t  m1_dat_i,
   output word_t       m1_dat_o,
   output logic        m1_ack_o,
   output logic        m1_err_o,

   input  wire flit_t  noc_in_flit_i,
   input  wire         noc_in_valid_i,
   output logic        noc_in_ready_o,
   output flit_t       noc_out_flit_o,
   output logic        noc_out_valid_o,
   input  wire         noc_out_ready_i,

   output logic        irq_o
);

   logic  [NR_SLAVES-1:0] s_cyc, s_stb, s_we, s_ack;
   word_t [NR_SLAVES-1:0] s_adr, s_dat_w, s_dat_r;
   sel_t  [NR_SLAVES-1:0] s_sel;

   wb_bus u_bus (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .m_cyc_i  ({m1_cyc_i, m0_cyc_i}),
      .m_stb_i  ({m1_stb_i, m0_stb_i}),
      .m_we_i   ({m1_we_i,  m0_we_i}),
      .m_adr_i  ({m1_adr_i, m0_adr_i}),
      .m_sel_i  ({m1_sel_i, m0_sel_i}),
      .m_dat_i  ({m1_dat_i, m0_dat_i}),
      .m_dat_o  ({m1_dat_o, m0_dat_o}),
      .m_ack_o  ({m1_ack_o, m0_ack_o}),
      .m_err_o  ({m1_err_o, m0_err_o}),
      .s_cyc_o  (s_cyc),
      .s_stb_o  (s_stb),
      .s_we_o   (s_we),
      .s_adr_o  (s_adr),
      .s_sel_o  (s_sel),
      .s_dat_o  (s_dat_w),
      .s_dat_i  (s_dat_r),
      .s_ack_i  (s_ack)
   );

   wb_sram #(.MEM_WORDS(MEM_WORDS)) u_ram (
      .clk_i (clk_i), .arst_n_i (arst_n_i),
      .cyc_i (s_cyc[SLV_RAM]), .stb_i (s_stb[SLV_RAM]), .we_i (s_we[SLV_RAM]),
      .adr_i (s_adr[SLV_RAM]), .sel_i (s_sel[SLV_RAM]), .dat_i (s_dat_w[SLV_RAM]),
      .dat_o (s_dat_r[SLV_RAM]), .ack_o (s_ack[SLV_RAM])
   );

   na_mp_simple #(.FIFO_DEPTH(FIFO_DEPTH)) u_na (
      .clk_i (clk_i), .arst_n_i (arst_n_i),
      .cyc_i (s_cyc[SLV_NA]), .stb_i (s_stb[SLV_NA]), .we_i (s_we[SLV_NA]),
      .adr_i (s_adr[SLV_NA]), .dat_i (s_dat_w[SLV_NA]),
      .dat_o (s_dat_r[SLV_NA]), .ack_o (s_ack[SLV_NA]),
      .noc_in_flit_i  (noc_in_flit_i),  .noc_in_valid_i  (noc_in_valid_i),
      .noc_in_ready_o (noc_in_ready_o), .noc_out_flit_o  (noc_out_flit_o),
      .noc_out_valid_o (noc_out_valid_o), .noc_out_ready_i (noc_out_ready_i),
      .irq_o (irq_o)
   );

   bootrom u_bootrom (
      .clk_i (clk_i), .arst_n_i (arst_n_i),
      .cyc_i (s_cyc[SLV_ROM]), .stb_i (s_stb[SLV_ROM]), .adr_i (s_adr[SLV_ROM]),
      .dat_o (s_dat_r[SLV_ROM]), .ack_o (s_ack[SLV_ROM])
   );

endmodule

`default_nettype wire

// File: tb/tb_compute_tile.sv
// Random Wishbone traffic on both master ports, checked against RAM, ROM and NoC models
// Assumes the default address map, RAM tests use only the lowest 64 words
`timescale 1ns/1ps
`default_nettype none

module tb_compute_tile import tile_pkg::*; ();

   localparam int MEM_WORDS      = 1024;
   localparam int FIFO_DEPTH     = 4;
   localparam int RAM_SPAN       = 64;        // Words touched by the RAM tests
   localparam int ACCESS_LIMIT   = 200;       // Cycles one bus access may take
   localparam int TIMEOUT_CYCLES = 20000;     // About four times the expected run

   logic  clk_i, arst_n_i;
   logic  m0_cyc_i, m0_stb_i, m0_we_i, m1_cyc_i, m1_stb_i, m1_we_i;
   word_t m0_adr_i, m0_dat_i, m1_adr_i, m1_dat_i;
   sel_t  m0_sel_i, m1_sel_i;
   word_t m0_dat_o, m1_dat_o;
   logic  m0_ack_o, m0_err_o, m1_ack_o, m1_err_o;
   flit_t noc_in_flit_i, noc_out_flit_o;
   logic  noc_in_valid_i, noc_in_ready_o, noc_out_valid_o, noc_out_ready_i, irq_o;

   word_t       ram_model [RAM_SPAN];
   flit_t       tx_q [$];                     // Flits written, not yet seen on the link
   flit_t       rx_q [$];                     // Flits injected, not yet read back
   flit_t       tx_exp;
   logic [31:0] seed;
   logic [31:0] sink_seed;
   logic        tx_phase;
   int          errors;
   int          checks;
   int          cycles;

   compute_tile #(.MEM_WORDS(MEM_WORDS), .FIFO_DEPTH(FIFO_DEPTH)) dut (.*);

   initial begin
      clk_i = 1'b0;
      forever #20 clk_i = ~clk_i;
   end

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Byte lanes with a set select take the new data
   function automatic word_t merge_bytes(input word_t old, input word_t nw, input sel_t sel);
      word_t r;
      r = old;
      for (int b = 0; b < 4; b++)
         if (sel[b])
            r[8*b +: 8] = nw[8*b +: 8];
      return r;
   endfunction

   task automatic compare(input string name, input word_t got, input word_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAILED %s: got %h, expected %h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic drive_port(input int port, input logic req, input logic we,
                             input word_t adr, input sel_t sel, input word_t dat);
      if (port == 0) begin
         m0_cyc_i <= req;
         m0_stb_i <= req;
         m0_we_i  <= we;
         m0_adr_i <= adr;
         m0_sel_i <= sel;
         m0_dat_i <= dat;
      end else begin
         m1_cyc_i <= req;
         m1_stb_i <= req;
         m1_we_i  <= we;
         m1_adr_i <= adr;
         m1_sel_i <= sel;
         m1_dat_i <= dat;
      end
   endtask

   // One classic cycle, held until ack or err
   task automatic wb_cycle(input int port, input logic we, input word_t adr, input sel_t sel,
                           input word_t wdat, output word_t rdat, output logic ack,
                           output logic err);
      int waited;
      @(posedge clk_i);
      drive_port(port, 1'b1, we, adr, sel, wdat);
      waited = 0;
      ack    = 1'b0;
      err    = 1'b0;
      rdat   = '0;
      while (!ack && !err && waited < ACCESS_LIMIT) begin
         @(posedge clk_i);
         waited++;
         ack  = (port == 0) ? m0_ack_o : m1_ack_o;
         err  = (port == 0) ? m0_err_o : m1_err_o;
         rdat = (port == 0) ? m0_dat_o : m1_dat_o;
      end
      drive_port(port, 1'b0, 1'b0, '0, '0, '0);
      if (!ack && !err) begin
         errors++;
         $display("Port %0d access to %h got neither ack nor err within %0d cycles",
                  port, adr, ACCESS_LIMIT);
      end
   endtask

   task automatic ram_write(input int port, input logic [5:0] idx, input sel_t sel,
                            input word_t data);
      word_t rd;
      logic  ack, err;
      wb_cycle(port, 1'b1, {24'h0, idx, 2'b00}, sel, data, rd, ack, err);
      compare($sformatf("m%0d_ack_o", port), 32'(ack), 32'd1);
      ram_model[idx] = merge_bytes(ram_model[idx], data, sel);
   endtask

   task automatic ram_read(input int port, input logic [5:0] idx);
      word_t rd;
      logic  ack, err;
      wb_cycle(port, 1'b0, {24'h0, idx, 2'b00}, 4'hF, '0, rd, ack, err);
      compare($sformatf("m%0d_dat_o", port), rd, ram_model[idx]);
   endtask

   // Own random state per port so both streams stay reproducible
   task automatic mixed_ram_traffic(input int port, input logic half, input logic [31:0] start);
      logic [31:0] st;
      logic [5:0]  idx;
      st = start;
      for (int k = 0; k < 40; k++) begin
         st  = xorshift(st);
         idx = {half, st[8:4]};
         if (st[0])
            ram_write(port, idx, st[15:12], xorshift(st));
         else
            ram_read(port, idx);
         repeat (int'(st[2:1])) @(posedge clk_i);
      end
   endtask

   task automatic inject_flits(input int n);
      flit_t f;
      for (int k = 0; k < n; k++) begin
         seed    = xorshift(seed);
         f.ftype = flit_type_e'(seed[1:0]);
         seed    = xorshift(seed);
         f.data  = seed;
         rx_q.push_back(f);
         @(posedge clk_i);
         noc_in_flit_i  <= f;
         noc_in_valid_i <= 1'b1;
         do begin
            @(posedge clk_i);
         end while (!noc_in_ready_o);                 // Accepted at this edge
         noc_in_valid_i <= 1'b0;
      end
   endtask

   // NoC sink, ready drops at random while the TX test runs
   always @(posedge clk_i) begin
      if (noc_out_valid_o && noc_out_ready_i) begin
         if (tx_q.size() == 0) begin
            errors++;
            $display("A flit left the tile while none was expected at %0t", $time);
         end else begin
            tx_exp = tx_q.pop_front();
            compare("noc_out_flit_o.ftype", 32'(noc_out_flit_o.ftype), 32'(tx_exp.ftype));
            compare("noc_out_flit_o.data", noc_out_flit_o.data, tx_exp.data);
         end
      end
      sink_seed = xorshift(sink_seed);
      noc_out_ready_i <= tx_phase ? (sink_seed[2:0] == 3'b000) : 1'b1;
   end

   initial begin
      cycles = 0;
      while (cycles < TIMEOUT_CYCLES) begin
         @(posedge clk_i);
         cycles++;
      end
      $display("Timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("CHECKS FAILED");
      $finish;
   end

   initial begin
      word_t      rd;
      logic       ack, err;
      flit_t      f;
      logic [3:0] nib;
      int         port;
      int         waited;
      errors    = 0;
      checks    = 0;
      seed      = 32'd89;
      sink_seed = 32'd89;
      arst_n_i        <= 1'b0;
      drive_port(0, 1'b0, 1'b0, '0, '0, '0);
      drive_port(1, 1'b0, 1'b0, '0, '0, '0);
      noc_in_flit_i   <= '0;
      noc_in_valid_i  <= 1'b0;
      noc_out_ready_i <= 1'b1;
      tx_phase        <= 1'b0;
      repeat (10) @(posedge clk_i);

      // Idle outputs while held in reset
      compare("m0_ack_o", 32'(m0_ack_o), 32'd0);
      compare("m0_err_o", 32'(m0_err_o), 32'd0);
      compare("m1_ack_o", 32'(m1_ack_o), 32'd0);
      compare("m1_err_o", 32'(m1_err_o), 32'd0);
      compare("noc_out_valid_o", 32'(noc_out_valid_o), 32'd0);
      compare("irq_o", 32'(irq_o), 32'd0);
      compare("noc_in_ready_o", 32'(noc_in_ready_o), 32'd1);
      arst_n_i <= 1'b1;

      // RAM: fill the window, then random byte writes with read back
      for (int i = 0; i < RAM_SPAN; i++) begin
         seed = xorshift(seed);
         ram_write(i % 2, 6'(i), 4'hF, seed);
      end
      for (int i = 0; i < 200; i++) begin
         seed = xorshift(seed);
         ram_write(int'(seed[0]), seed[9:4], seed[15:12], xorshift(seed));
         seed = xorshift(seed);
         ram_read(int'(seed[0]), seed[9:4]);
      end

      // Boot ROM, including the alias above ROM_WORDS
      for (int i = 0; i < 40; i++) begin
         wb_cycle(i % 2, 1'b0, 32'hF000_0000 + 32'(4 * i), 4'hF, '0, rd, ack, err);
         compare($sformatf("m%0d_dat_o", i % 2), rd,
                 32'hB007_0000 + 32'(i % ROM_WORDS) * 32'h0000_0101);
      end

      for (int i = 0; i < 12; i++) begin
         seed = xorshift(seed);
         nib  = 4'(32'd8 + seed % 32'd6);             // Top nibble 8..D
         seed = xorshift(seed);
         wb_cycle(i % 2, seed[0], {nib, seed[31:4]}, seed[3:0], seed, rd, ack, err);
         compare($sformatf("m%0d_err_o", i % 2), 32'(err), 32'd1);
         compare($sformatf("m%0d_ack_o", i % 2), 32'(ack), 32'd0);
      end

      // Transmit under random back-pressure
      tx_phase <= 1'b1;
      for (int i = 0; i < 24; i++) begin
         seed    = xorshift(seed);
         port    = int'(seed[2]);
         f.ftype = flit_type_e'(seed[1:0]);
         seed    = xorshift(seed);
         f.data  = seed;
         tx_q.push_back(f);
         wb_cycle(port, 1'b1, {4'hE, 24'h0, f.ftype, 2'b00}, 4'hF, f.data, rd, ack, err);
         compare($sformatf("m%0d_ack_o", port), 32'(ack), 32'd1);
      end
      waited = 0;
      while (tx_q.size() != 0 && waited < ACCESS_LIMIT) begin
         @(posedge clk_i);
         waited++;
      end
      if (tx_q.size() != 0) begin
         errors++;
         $display("%0d written flits never left the tile", tx_q.size());
      end
      tx_phase <= 1'b0;

      // Receive, status and RX_DATA per flit
      for (int round = 0; round < 2; round++) begin
         inject_flits(FIFO_DEPTH - 1 + round);
         @(posedge clk_i);
         compare("irq_o", 32'(irq_o), 32'd1);
         compare("noc_in_ready_o", 32'(noc_in_ready_o), 32'(rx_q.size() < FIFO_DEPTH));
         while (rx_q.size() != 0) begin
            f = rx_q.pop_front();
            wb_cycle(round, 1'b0, 32'hE000_0014, 4'hF, '0, rd, ack, err);
            compare($sformatf("m%0d_dat_o", round), rd, {28'h0, 1'b0, f.ftype, 1'b1});
            wb_cycle(round, 1'b0, 32'hE000_0010, 4'hF, '0, rd, ack, err);
            compare($sformatf("m%0d_dat_o", round), rd, f.data);
         end
         compare("irq_o", 32'(irq_o), 32'd0);
         wb_cycle(round, 1'b0, 32'hE000_0010, 4'hF, '0, rd, ack, err);
         compare($sformatf("m%0d_dat_o", round), rd, 32'd0);
      end

      // Both ports at once on disjoint halves
      seed = xorshift(seed);
      fork
         mixed_ram_traffic(0, 1'b0, seed);
         mixed_ram_traffic(1, 1'b1, ~seed);
      join

      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: flist.f
verilog/tile_pkg.sv
verilog/wb_bus.sv
verilog/wb_sram.sv
verilog/bootrom.sv
verilog/na_mp_simple.sv
verilog/compute_tile.sv
tb/tb_compute_tile.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the compute tile testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f flist.f --top-module tb_compute_tile \
   -Mdir obj_dir -o sim_tile

out="$(./obj_dir/sim_tile)"
echo "$out"

if echo "$out" | grep -qx "ALL CHECKS PASSED"; then
   exit 0
fi
exit 1
